/* Bender.yml */
package:
  name: spi_subsystem

sources:
  - files:
      - spi_pkg.sv
      - spi_if.sv
      - spi_regs.sv
      - spi_fifo.sv
      - spi_controller.sv
      - spi_interface.sv
      - spi_subsystem.sv
  - target: test
    files:
      - spi_periph_model.sv
      - spi_subsystem_checker.sv
      - tb_spi_subsystem.sv

/* list.f */
spi_pkg.sv
spi_if.sv
spi_regs.sv
spi_fifo.sv
spi_controller.sv
spi_interface.sv
spi_subsystem.sv
spi_periph_model.sv
spi_subsystem_checker.sv
tb_spi_subsystem.sv

/* spi_controller.sv */
/*
  SPI mode 0 master, one frame is the direction bit, the address and xfer_len words, MSB first
  the command FIFO head must already hold the first word, so the FIFO needs a prefetch pop
*/
`timescale 1ns/100ps
`default_nettype none

module spi_controller (
  input  logic        S_AXI_ACLK,
  input  logic        S_AXI_ARESETN,
  spi_xfer_if.ctrl    xfer,
  spi_buf_if.reader   cmd_buf,
  spi_buf_if.writer   read_buf,
  input  logic        poci,
  output logic        pico,
  output logic        cs_b,
  output logic        spi_clk
);

  localparam int DIV_W = (spi_pkg::SPI_CLK_DIV > 1) ? $clog2(spi_pkg::SPI_CLK_DIV) : 1;
  localparam int BIT_W = $clog2(spi_pkg::DATA_WIDTH);
  localparam int HDR_BITS = spi_pkg::ADDR_WIDTH + 1;

  typedef enum logic [2:0] {
    S_IDLE,
    S_HEADER,
    S_WRITE,
    S_READ,
    S_FINISH
  } state_t;

  state_t state;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic [spi_pkg::LEN_WIDTH-1:0] len_left;
  logic [spi_pkg::DATA_WIDTH-1:0] out_word;
  logic [spi_pkg::DATA_WIDTH-1:0] in_word;
  logic tick;
  logic rise;
  logic fall;
  logic last_bit;
  logic last_word;

  // tick marks the end of each spi_clk half-period
  assign tick = (div_cnt == DIV_W'(spi_pkg::SPI_CLK_DIV - 1));
  // spi_clk only toggles while bits are on the wire, never in S_FINISH
  assign rise = tick && !spi_clk && (state inside {S_HEADER, S_WRITE, S_READ});
  assign fall = tick && spi_clk;
  assign last_bit = (bit_cnt == '0);
  assign last_word = (len_left == spi_pkg::LEN_WIDTH'(1));
  // the outgoing bit is the top of the shift register, which is zero when idle
  assign pico = out_word[spi_pkg::DATA_WIDTH-1];

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state <= S_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      len_left <= '0;
      out_word <= '0;
      cs_b <= 1'b1;
      spi_clk <= 1'b0;
      cmd_buf.pop <= 1'b0;
      read_buf.push <= 1'b0;
      xfer.done <= 1'b0;
    end else begin
      cmd_buf.pop <= 1'b0;
      read_buf.push <= 1'b0;
      xfer.done <= 1'b0;
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      if (rise) begin
        spi_clk <= 1'b1;
      end
      if (fall) begin
        spi_clk <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          div_cnt <= '0;
          // xfer_len is still set during the done cycle, so done blocks a restart
          if (xfer.xfer_len != '0 && !xfer.done) begin
            out_word <= {xfer.xfer_dir, xfer.xfer_addr,
                         {(spi_pkg::DATA_WIDTH - HDR_BITS){1'b0}}};
            bit_cnt <= BIT_W'(HDR_BITS - 1);
            len_left <= xfer.xfer_len;
            cs_b <= 1'b0;
            // load the first command word into the head well before it is needed
            cmd_buf.pop <= xfer.xfer_dir && !cmd_buf.empty;
            state <= S_HEADER;
          end
        end
        S_HEADER, S_WRITE, S_READ: begin
          // pico moves on the falling edge, one bit per spi_clk period
          if (fall) begin
            out_word <= {out_word[spi_pkg::DATA_WIDTH-2:0], 1'b0};
            bit_cnt <= bit_cnt - 1'b1;
            if (last_bit) begin
              bit_cnt <= BIT_W'(spi_pkg::DATA_WIDTH - 1);
              if (state == S_HEADER) begin
                if (xfer.xfer_dir) begin
                  out_word <= cmd_buf.head;
                  cmd_buf.pop <= !cmd_buf.empty;
                  state <= S_WRITE;
                end else begin
                  state <= S_READ;
                end
              end else begin
                // a full word has been sent or received
                read_buf.push <= (state == S_READ) && !read_buf.full;
                len_left <= len_left - 1'b1;
                if (last_word) begin
                  state <= S_FINISH;
                end else if (state == S_WRITE) begin
                  out_word <= cmd_buf.head;
                  cmd_buf.pop <= !cmd_buf.empty;
                end
              end
            end
          end
        end
        S_FINISH: begin
          // hold cs_b low for one more half-period after the last falling edge
          if (tick) begin
            cs_b <= 1'b1;
            xfer.done <= 1'b1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // poci is sampled on the rising edge, the finished word goes out with the push
  always_ff @(posedge S_AXI_ACLK) begin
    if (rise) begin
      in_word <= {in_word[spi_pkg::DATA_WIDTH-2:0], poci};
    end
    if (fall && last_bit) begin
      read_buf.push_word <= in_word;
    end
  end

endmodule

`default_nettype wire

/* spi_fifo.sv */
/*
  synchronous FIFO whose head is a register loaded by each pop
  after a pop the popped word sits on head until the next pop
*/
`timescale 1ns/100ps
`default_nettype none

module spi_fifo #(
  parameter int DEPTH = spi_pkg::FIFO_DEPTH
) (
  input  logic      S_AXI_ACLK,
  input  logic      S_AXI_ARESETN,
  spi_buf_if.fifo   buf_port
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [spi_pkg::DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic do_push;
  logic do_pop;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // count only covers stored words, the head register is not part of it
  assign buf_port.full = (count == CNT_W'(DEPTH));
  assign buf_port.empty = (count == '0);
  assign do_push = buf_port.push && !buf_port.full;
  assign do_pop = buf_port.pop && !buf_port.empty;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // storage and head hold data only
  always_ff @(posedge S_AXI_ACLK) begin
    if (do_push) begin
      mem[wr_ptr] <= buf_port.push_word;
    end
    if (do_pop) begin
      buf_port.head <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

/* spi_if.sv */
/*
  FIFO access bundle and transfer bundle used inside spi_interface
  pushing a full FIFO or popping an empty one is ignored by the FIFO
*/
`timescale 1ns/100ps
`default_nettype none

interface spi_buf_if;

  // writer side
  logic push;
  logic [spi_pkg::DATA_WIDTH-1:0] push_word;
  logic full;

  // reader side, head is the word that the last pop loaded
  logic pop;
  logic [spi_pkg::DATA_WIDTH-1:0] head;
  logic empty;

  modport writer (output push, output push_word, input full);
  modport reader (output pop, input head, input empty);
  modport fifo (input push, input push_word, input pop, output full, output head, output empty);

endinterface

interface spi_xfer_if;

  // transfer parameters locked by spi_interface while busy
  logic xfer_dir;
  logic [spi_pkg::ADDR_WIDTH-1:0] xfer_addr;
  logic [spi_pkg::LEN_WIDTH-1:0] xfer_len;
  // one-cycle pulse from the controller once cs_b is back high
  logic done;

  modport ctrl (input xfer_dir, input xfer_addr, input xfer_len, output done);

endinterface

`default_nettype wire

/* spi_interface.sv */
/*
  locks the transfer parameters while busy and owns every FIFO push and pop
  a start or a command push during a transfer is dropped, and so is a pop of the read FIFO
*/
`timescale 1ns/100ps
`default_nettype none

module spi_interface (
  input  logic                            S_AXI_ACLK,
  input  logic                            S_AXI_ARESETN,
  input  logic                            direction,
  input  logic [spi_pkg::ADDR_WIDTH-1:0]  spi_addr,
  input  logic [spi_pkg::LEN_WIDTH-1:0]   data_len,
  input  logic                            len_wr,
  input  logic                            wdata_wr,
  input  logic [spi_pkg::DATA_WIDTH-1:0]  write_word,
  input  logic                            rdata_rd,
  output logic                            busy,
  output logic                            read_empty,
  output logic                            cmd_full,
  output logic [spi_pkg::DATA_WIDTH-1:0]  read_head,
  input  logic                            poci,
  output logic                            pico,
  output logic                            cs_b,
  output logic                            spi_clk
);

  spi_buf_if cmd_q ();
  spi_buf_if read_q ();
  spi_xfer_if xfer ();

  // high in the done cycle of a read, when the first received word moves to the head
  logic prefetch;

  // the controller only ever sees these locked copies
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      busy <= 1'b0;
      xfer.xfer_dir <= 1'b0;
      xfer.xfer_addr <= '0;
      xfer.xfer_len <= '0;
    end else if (busy && xfer.done) begin
      // zeroing the length keeps the controller from starting over
      busy <= 1'b0;
      xfer.xfer_len <= '0;
    end else if (!busy && len_wr && data_len != '0) begin
      busy <= 1'b1;
      xfer.xfer_dir <= direction;
      xfer.xfer_addr <= spi_addr;
      xfer.xfer_len <= data_len;
    end
  end

  assign prefetch = busy && xfer.done && !xfer.xfer_dir;

  // host pushes only between transfers, and never into a full FIFO
  assign cmd_q.push = wdata_wr && !busy && !cmd_q.full;
  assign cmd_q.push_word = write_word;

  // a host read pops the word that follows the one it has just returned
  assign read_q.pop = (prefetch || (rdata_rd && !busy)) && !read_q.empty;

  assign read_empty = read_q.empty;
  assign cmd_full = cmd_q.full;
  assign read_head = read_q.head;

  spi_fifo #(
    .DEPTH(spi_pkg::FIFO_DEPTH)
  ) cmd_buffer (
    .S_AXI_ACLK(S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .buf_port(cmd_q.fifo)
  );

  spi_fifo #(
    .DEPTH(spi_pkg::FIFO_DEPTH)
  ) read_buffer (
    .S_AXI_ACLK(S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .buf_port(read_q.fifo)
  );

  spi_controller u_controller (
    .S_AXI_ACLK(S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .xfer(xfer.ctrl),
    .cmd_buf(cmd_q.reader),
    .read_buf(read_q.writer),
    .poci(poci),
    .pico(pico),
    .cs_b(cs_b),
    .spi_clk(spi_clk)
  );

endmodule

`default_nettype wire

/* spi_periph_model.sv */
/*
  behavioral SPI mode 0 peripheral with a 16-word buffer, stores written words in order
  read frames return the buffer inverted and XORed with the frame address, MSB first
*/
`timescale 1ns/100ps
`default_nettype none

module spi_periph_model (
  input  logic cs_b,
  input  logic spi_clk,
  input  logic pico,
  output logic poci
);

  localparam int HDR_BITS = spi_pkg::ADDR_WIDTH + 1;
  localparam int WORD_BITS = spi_pkg::DATA_WIDTH;

  logic [spi_pkg::DATA_WIDTH-1:0] mem [spi_pkg::FIFO_DEPTH];
  logic [HDR_BITS-1:0] header;
  logic [spi_pkg::DATA_WIDTH-1:0] shift_in;
  logic [spi_pkg::DATA_WIDTH-1:0] reply;
  logic [spi_pkg::ADDR_WIDTH-1:0] last_addr;
  logic last_dir;
  int frame_count;
  int bit_count;
  int rx_idx;
  int tx_idx;
  int tx_pos;

  initial begin
    for (int i = 0; i < spi_pkg::FIFO_DEPTH; i++) begin
      mem[i] = '0;
    end
    poci = 1'b0;
    last_addr = '0;
    last_dir = 1'b0;
    frame_count = 0;
    bit_count = 0;
  end

  // every falling cs_b opens a new frame
  always @(negedge cs_b) begin
    bit_count = 0;
    frame_count++;
  end

  // pico is sampled on the rising edge
  always @(posedge spi_clk) begin
    if (cs_b === 1'b0) begin
      if (bit_count < HDR_BITS) begin
        header = {header[HDR_BITS-2:0], pico};
        if (bit_count == HDR_BITS - 1) begin
          last_dir = header[HDR_BITS-1];
          last_addr = header[spi_pkg::ADDR_WIDTH-1:0];
        end
      end else begin
        shift_in = {shift_in[WORD_BITS-2:0], pico};
        rx_idx = (bit_count - HDR_BITS) / WORD_BITS;
        // a write word is complete on its 32nd bit
        if (last_dir && ((bit_count - HDR_BITS) % WORD_BITS == WORD_BITS - 1) &&
            rx_idx < spi_pkg::FIFO_DEPTH) begin
          mem[rx_idx] = shift_in;
        end
      end
      bit_count++;
    end
  end

  // poci moves on the falling edge, starting right after the last header bit
  always @(negedge spi_clk) begin
    if (cs_b === 1'b0 && bit_count >= HDR_BITS && !last_dir) begin
      tx_idx = (bit_count - HDR_BITS) / WORD_BITS;
      tx_pos = WORD_BITS - 1 - ((bit_count - HDR_BITS) % WORD_BITS);
      if (tx_idx < spi_pkg::FIFO_DEPTH) begin
        reply = ~mem[tx_idx] ^ spi_pkg::DATA_WIDTH'(last_addr);
        poci = reply[tx_pos];
      end
    end
  end

endmodule

`default_nettype wire

/* spi_pkg.sv */
/*
  shared widths, sizes and register map of the SPI master subsystem
  transfers longer than FIFO_DEPTH words are not supported
*/
`default_nettype none

package spi_pkg;

  // register bus and FIFO word width
  localparam int DATA_WIDTH = 32;

  // peripheral address sent after the direction bit
  localparam int ADDR_WIDTH = 10;

  // word count register width
  localparam int LEN_WIDTH = 8;

  // entries in the command FIFO and in the read FIFO
  localparam int FIFO_DEPTH = 16;

  // bus clocks per spi_clk half-period
  localparam int SPI_CLK_DIV = 4;

  // register map, one word address per register
  localparam int REG_ADDR_WIDTH = 3;
  localparam int REG_COUNT = 6;

  // bit 0 holds the direction, 1 means write
  localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL = 3'd0;
  localparam logic [REG_ADDR_WIDTH-1:0] REG_ADDR = 3'd1;
  // a non-zero write starts a transfer
  localparam logic [REG_ADDR_WIDTH-1:0] REG_LEN = 3'd2;
  // every write pushes one word into the command FIFO
  localparam logic [REG_ADDR_WIDTH-1:0] REG_WDATA = 3'd3;
  // every read returns the read FIFO head and pops the next word
  localparam logic [REG_ADDR_WIDTH-1:0] REG_RDATA = 3'd4;
  // busy, read FIFO empty and command FIFO full in bits 0 to 2
  localparam logic [REG_ADDR_WIDTH-1:0] REG_STATUS = 3'd5;

endpackage

`default_nettype wire

/* spi_regs.sv */
/*
  host register file, writes land one cycle after reg_wr and the strobes follow a cycle later
  reg_rdata is combinational and follows reg_addr in the same cycle
*/
`timescale 1ns/100ps
`default_nettype none

module spi_regs (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  logic                                reg_wr,
  input  logic                                reg_rd,
  input  logic [spi_pkg::REG_ADDR_WIDTH-1:0]  reg_addr,
  input  logic [spi_pkg::DATA_WIDTH-1:0]      reg_wdata,
  output logic [spi_pkg::DATA_WIDTH-1:0]      reg_rdata,
  output logic                                direction,
  output logic [spi_pkg::ADDR_WIDTH-1:0]      spi_addr,
  output logic [spi_pkg::LEN_WIDTH-1:0]       data_len,
  output logic                                len_wr,
  output logic                                wdata_wr,
  output logic [spi_pkg::DATA_WIDTH-1:0]      write_word,
  output logic                                rdata_rd,
  input  logic                                busy,
  input  logic                                read_empty,
  input  logic                                cmd_full,
  input  logic [spi_pkg::DATA_WIDTH-1:0]      read_head
);

  // writes to the two unused word addresses are dropped
  logic wr_hit;

  assign wr_hit = reg_wr && (int'(reg_addr) < spi_pkg::REG_COUNT);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      direction <= 1'b0;
      spi_addr <= '0;
      data_len <= '0;
      len_wr <= 1'b0;
      wdata_wr <= 1'b0;
      rdata_rd <= 1'b0;
    end else begin
      // strobes are high in the cycle after the register has taken its new value
      len_wr <= wr_hit && (reg_addr == spi_pkg::REG_LEN);
      wdata_wr <= wr_hit && (reg_addr == spi_pkg::REG_WDATA);
      rdata_rd <= reg_rd && (reg_addr == spi_pkg::REG_RDATA);
      if (wr_hit) begin
        case (reg_addr)
          spi_pkg::REG_CTRL: direction <= reg_wdata[0];
          spi_pkg::REG_ADDR: spi_addr <= reg_wdata[spi_pkg::ADDR_WIDTH-1:0];
          spi_pkg::REG_LEN: data_len <= reg_wdata[spi_pkg::LEN_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // the word to push travels alongside wdata_wr
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_hit && (reg_addr == spi_pkg::REG_WDATA)) begin
      write_word <= reg_wdata;
    end
  end

  // readback mux, the read FIFO head is shown before the pop that follows it
  always_comb begin
    reg_rdata = '0;
    case (reg_addr)
      spi_pkg::REG_CTRL: reg_rdata[0] = direction;
      spi_pkg::REG_ADDR: reg_rdata[spi_pkg::ADDR_WIDTH-1:0] = spi_addr;
      spi_pkg::REG_LEN: reg_rdata[spi_pkg::LEN_WIDTH-1:0] = data_len;
      spi_pkg::REG_WDATA: reg_rdata = write_word;
      spi_pkg::REG_RDATA: reg_rdata = read_head;
      spi_pkg::REG_STATUS: reg_rdata[2:0] = {cmd_full, read_empty, busy};
      default: reg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* spi_subsystem.sv */
/*
  SPI master behind a strobe register port, single chip select and SPI mode 0 only
  the host spaces REG_RDATA reads by at least 3 cycles and polls busy in REG_STATUS
*/
`timescale 1ns/100ps
`default_nettype none

module spi_subsystem (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  logic                                reg_wr,
  input  logic                                reg_rd,
  input  logic [spi_pkg::REG_ADDR_WIDTH-1:0]  reg_addr,
  input  logic [spi_pkg::DATA_WIDTH-1:0]      reg_wdata,
  output logic [spi_pkg::DATA_WIDTH-1:0]      reg_rdata,
  input  logic                                poci,
  output logic                                pico,
  output logic                                cs_b,
  output logic                                spi_clk
);

  // latched register values and their strobes
  logic direction;
  logic [spi_pkg::ADDR_WIDTH-1:0] spi_addr;
  logic [spi_pkg::LEN_WIDTH-1:0] data_len;
  logic len_wr;
  logic wdata_wr;
  logic [spi_pkg::DATA_WIDTH-1:0] write_word;
  logic rdata_rd;

  // status and read data going back to the register file
  logic busy;
  logic read_empty;
  logic cmd_full;
  logic [spi_pkg::DATA_WIDTH-1:0] read_head;

  spi_regs u_spi_regs (
    .S_AXI_ACLK(S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .reg_wr(reg_wr),
    .reg_rd(reg_rd),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .reg_rdata(reg_rdata),
    .direction(direction),
    .spi_addr(spi_addr),
    .data_len(data_len),
    .len_wr(len_wr),
    .wdata_wr(wdata_wr),
    .write_word(write_word),
    .rdata_rd(rdata_rd),
    .busy(busy),
    .read_empty(read_empty),
    .cmd_full(cmd_full),
    .read_head(read_head)
  );

  spi_interface u_spi_interface (
    .S_AXI_ACLK(S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .direction(direction),
    .spi_addr(spi_addr),
    .data_len(data_len),
    .len_wr(len_wr),
    .wdata_wr(wdata_wr),
    .write_word(write_word),
    .rdata_rd(rdata_rd),
    .busy(busy),
    .read_empty(read_empty),
    .cmd_full(cmd_full),
    .read_head(read_head),
    .poci(poci),
    .pico(pico),
    .cs_b(cs_b),
    .spi_clk(spi_clk)
  );

endmodule

`default_nettype wire

/* spi_subsystem_checker.sv */
/*
  protocol assertions bound into spi_interface, all idle during reset
*/
`timescale 1ns/100ps
`default_nettype none

module spi_subsystem_checker (
  input logic S_AXI_ACLK,
  input logic S_AXI_ARESETN,
  input logic busy,
  input logic cs_b,
  input logic done,
  input logic cmd_pop,
  input logic cmd_empty,
  input logic read_push,
  input logic read_full
);

  // the chip select may only drop inside a locked transfer
  cs_high_when_idle: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    !busy |-> cs_b) else $error("cs_b low while not busy");

  // the controller registers its read FIFO pushes a cycle before the FIFO sees them
  no_push_into_full: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    !(read_push && read_full)) else $error("push into a full FIFO");

  // command FIFO pops come from the controller, one cycle after it looked at empty
  no_pop_from_empty: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    !(cmd_pop && cmd_empty)) else $error("pop from an empty FIFO");

  // done ends a transfer, so it cannot come while idle
  done_only_when_busy: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    done |-> busy) else $error("done pulse while not busy");

endmodule

`default_nettype wire

/* tb_spi_subsystem.sv */
/*
  testbench for spi_subsystem with a behavioral peripheral on the SPI pins
  expected words follow the peripheral rule, data comes from an xorshift generator
*/
`timescale 1ns/100ps
`default_nettype none

module tb_spi_subsystem;

  localparam int TIMEOUT_POLLS = 20000;
  localparam int READ_GAP = 3;

  logic S_AXI_ACLK;
  logic S_AXI_ARESETN;
  logic reg_wr;
  logic reg_rd;
  logic [spi_pkg::REG_ADDR_WIDTH-1:0] reg_addr;
  logic [spi_pkg::DATA_WIDTH-1:0] reg_wdata;
  logic [spi_pkg::DATA_WIDTH-1:0] reg_rdata;
  logic poci;
  logic pico;
  logic cs_b;
  logic spi_clk;

  // copy of what the peripheral buffer should hold
  logic [spi_pkg::DATA_WIDTH-1:0] shadow [spi_pkg::FIFO_DEPTH];
  logic [31:0] rng;
  int checks = 0;
  int errors = 0;
  int test_errors = 0;
  int stray_edges = 0;

  // pending comparisons, consumed by the comparing process
  logic [31:0] obs_q[$];
  logic [31:0] exp_q[$];
  string name_q[$];

  initial S_AXI_ACLK = 1'b0;
  always #4 S_AXI_ACLK = ~S_AXI_ACLK;

  spi_subsystem u_spi_subsystem (
    .S_AXI_ACLK(S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .reg_wr(reg_wr),
    .reg_rd(reg_rd),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .reg_rdata(reg_rdata),
    .poci(poci),
    .pico(pico),
    .cs_b(cs_b),
    .spi_clk(spi_clk)
  );

  spi_periph_model u_periph (
    .cs_b(cs_b),
    .spi_clk(spi_clk),
    .pico(pico),
    .poci(poci)
  );

  bind spi_interface spi_subsystem_checker u_checker (
    .S_AXI_ACLK(S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .busy(busy),
    .cs_b(cs_b),
    .done(xfer.done),
    .cmd_pop(cmd_q.pop),
    .cmd_empty(cmd_q.empty),
    .read_push(read_q.push),
    .read_full(read_q.full)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // written words arrive unchanged, read words come back inverted and XORed with the address
  function automatic logic [31:0] expected_word(input logic is_read, input logic [31:0] stored,
                                                input logic [spi_pkg::ADDR_WIDTH-1:0] addr);
    if (is_read) begin
      return ~stored ^ 32'(addr);
    end
    return stored;
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic queue_compare(input string name, input logic [31:0] observed,
                               input logic [31:0] expected);
    name_q.push_back(name);
    obs_q.push_back(observed);
    exp_q.push_back(expected);
  endtask

  // compares every pending pair in the middle of the clock cycle
  always @(negedge S_AXI_ACLK) begin
    while (obs_q.size() > 0 && exp_q.size() > 0) begin
      check(name_q.pop_front(), obs_q.pop_front(), exp_q.pop_front());
    end
  end

  // any spi_clk movement outside a frame is counted
  always @(spi_clk) begin
    if (S_AXI_ARESETN === 1'b1 && cs_b !== 1'b0) begin
      stray_edges++;
    end
  end

  task automatic abort_run();
    $display("checks %0d, errors %0d", checks, errors);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge S_AXI_ACLK);
  endtask

  task automatic reg_write(input logic [spi_pkg::REG_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] data);
    @(posedge S_AXI_ACLK);
    reg_wr <= 1'b1;
    reg_addr <= addr;
    reg_wdata <= data;
    @(posedge S_AXI_ACLK);
    reg_wr <= 1'b0;
  endtask

  // reg_rdata is sampled mid-cycle while reg_rd is high
  task automatic reg_read(input logic [spi_pkg::REG_ADDR_WIDTH-1:0] addr,
                          output logic [31:0] data);
    @(posedge S_AXI_ACLK);
    reg_rd <= 1'b1;
    reg_addr <= addr;
    @(negedge S_AXI_ACLK);
    data = reg_rdata;
    @(posedge S_AXI_ACLK);
    reg_rd <= 1'b0;
  endtask

  task automatic wait_idle(input string what);
    logic [31:0] status;
    int polls;
    polls = 0;
    reg_read(spi_pkg::REG_STATUS, status);
    while (status[0] && polls < TIMEOUT_POLLS) begin
      polls++;
      reg_read(spi_pkg::REG_STATUS, status);
    end
    if (status[0]) begin
      $display("timeout: busy never cleared during %s", what);
      abort_run();
    end
  endtask

  task automatic drain_compares();
    int cycles;
    cycles = 0;
    while (exp_q.size() > 0 && cycles < 16) begin
      @(posedge S_AXI_ACLK);
      cycles++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout: %0d comparisons still pending", exp_q.size());
      abort_run();
    end
  endtask

  task automatic finish_test(input int n, input string name);
    drain_compares();
    $display("test %0d %s: %s", n, name, (test_errors == 0) ? "ok" : "failed");
    test_errors = 0;
  endtask

  // the length goes last, its write is what starts the frame
  task automatic start_transfer(input logic dir, input logic [spi_pkg::ADDR_WIDTH-1:0] addr,
                                input int len);
    reg_write(spi_pkg::REG_CTRL, 32'(dir));
    reg_write(spi_pkg::REG_ADDR, 32'(addr));
    reg_write(spi_pkg::REG_LEN, 32'(len));
  endtask

  task automatic push_words(input int len);
    int i;
    for (i = 0; i < len; i++) begin
      rng = xorshift32(rng);
      shadow[i] = rng;
      reg_write(spi_pkg::REG_WDATA, rng);
    end
  endtask

  task automatic check_write(input logic [spi_pkg::ADDR_WIDTH-1:0] addr, input int len);
    int i;
    queue_compare("periph last_dir", 32'(u_periph.last_dir), 32'd1);
    queue_compare("periph last_addr", 32'(u_periph.last_addr), 32'(addr));
    for (i = 0; i < len; i++) begin
      queue_compare($sformatf("periph mem[%0d]", i), u_periph.mem[i],
                    expected_word(1'b0, shadow[i], addr));
    end
  endtask

  task automatic write_frame(input logic [spi_pkg::ADDR_WIDTH-1:0] addr, input int len);
    push_words(len);
    start_transfer(1'b1, addr, len);
    wait_idle("write frame");
    check_write(addr, len);
  endtask

  // reads are spaced so the next head has been loaded
  task automatic read_frame(input logic [spi_pkg::ADDR_WIDTH-1:0] addr, input int len);
    logic [31:0] data;
    int i;
    start_transfer(1'b0, addr, len);
    wait_idle("read frame");
    for (i = 0; i < len; i++) begin
      reg_read(spi_pkg::REG_RDATA, data);
      queue_compare($sformatf("reg_rdata word %0d", i), data,
                    expected_word(1'b1, shadow[i], addr));
      idle_cycles(READ_GAP);
    end
    reg_read(spi_pkg::REG_STATUS, data);
    check("status read_empty", 32'(data[1]), 32'd1);
  endtask

  initial begin
    logic [31:0] status;
    logic [spi_pkg::ADDR_WIDTH-1:0] addr_a;
    logic dir;
    int frames;
    int len;
    int n;
    rng = 32'd77115;
    for (n = 0; n < spi_pkg::FIFO_DEPTH; n++) begin
      shadow[n] = '0;
    end
    reg_wr = 1'b0;
    reg_rd = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    S_AXI_ARESETN = 1'b0;
    repeat (8) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    idle_cycles(2);

    // idle state after reset
    reg_read(spi_pkg::REG_STATUS, status);
    check("status busy", 32'(status[0]), 32'd0);
    check("status read_empty", 32'(status[1]), 32'd1);
    check("status cmd_full", 32'(status[2]), 32'd0);
    idle_cycles(20);
    check("cs_b", 32'(cs_b), 32'd1);
    check("pico", 32'(pico), 32'd0);
    check("stray spi_clk edges", stray_edges, 0);
    finish_test(1, "reset state");

    rng = xorshift32(rng);
    addr_a = rng[spi_pkg::ADDR_WIDTH-1:0];
    write_frame(addr_a, 4);
    finish_test(2, "write 4 words");

    read_frame(addr_a ^ 10'h155, 4);
    finish_test(3, "read 4 words");

    // ADDR and LEN writes during a frame must not reach the locked transfer
    frames = u_periph.frame_count;
    rng = xorshift32(rng);
    addr_a = rng[spi_pkg::ADDR_WIDTH-1:0];
    push_words(2);
    start_transfer(1'b1, addr_a, 2);
    reg_read(spi_pkg::REG_STATUS, status);
    check("status busy", 32'(status[0]), 32'd1);
    reg_write(spi_pkg::REG_ADDR, 32'(~addr_a));
    reg_write(spi_pkg::REG_LEN, 32'd3);
    wait_idle("locked write frame");
    idle_cycles(64);
    check("periph frame_count", u_periph.frame_count, frames + 1);
    check_write(addr_a, 2);
    finish_test(4, "locked transfer");

    // two extra pushes past the FIFO depth are dropped
    push_words(spi_pkg::FIFO_DEPTH);
    repeat (2) begin
      rng = xorshift32(rng);
      reg_write(spi_pkg::REG_WDATA, rng);
    end
    reg_read(spi_pkg::REG_STATUS, status);
    check("status cmd_full", 32'(status[2]), 32'd1);
    rng = xorshift32(rng);
    addr_a = rng[spi_pkg::ADDR_WIDTH-1:0];
    start_transfer(1'b1, addr_a, spi_pkg::FIFO_DEPTH);
    wait_idle("full write frame");
    check_write(addr_a, spi_pkg::FIFO_DEPTH);
    reg_read(spi_pkg::REG_STATUS, status);
    check("status cmd_full", 32'(status[2]), 32'd0);
    finish_test(5, "command FIFO overflow");

    for (n = 0; n < 6; n++) begin
      rng = xorshift32(rng);
      dir = rng[0];
      len = 1 + int'(rng[10:8]);
      addr_a = rng[16 +: spi_pkg::ADDR_WIDTH];
      if (dir) begin
        write_frame(addr_a, len);
      end else begin
        read_frame(addr_a, len);
      end
    end
    check("stray spi_clk edges", stray_edges, 0);
    finish_test(6, "random back to back");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
